//--- hdl/fetch_pkg.sv
// ==========================================================================
// fetch package
// widths, reset pc, rom geometry and the enums of the fetch front end
// ==========================================================================
package fetch_pkg;

	// datapath widths
	localparam int ADDR_W  = 32;
	localparam int INSTR_W = 32;

	// first fetch address out of reset
	localparam logic [ADDR_W-1:0] RESET_PC = '0;

	// instruction rom geometry and access timing
	localparam int ROM_DEPTH = 16;
	localparam int ROM_WAIT  = 1;

	// next pc source
	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_JR} pc_sel_e;

	// fetch controller states
	typedef enum logic [1:0] {IDLE, SETUP, ACCESS, FULL} fetch_state_e;

	// jump code from the later stages
	typedef enum logic [1:0] {J_NONE, J_JUMP, J_REG} jump_e;

endpackage

//--- hdl/apb_if.sv
// ==========================================================================
// apb read interface
// one requester, one completer, read transfers only
// ==========================================================================
`timescale 1ns/1ps

interface apb_if;
	import fetch_pkg::*;

	logic [ADDR_W-1:0]  paddr;
	logic               psel;
	logic               penable;
	logic               pwrite;
	logic [INSTR_W-1:0] prdata;
	logic               pready;

	// fetch side, split between the controller and pc_gen
	modport requester (
		output paddr, psel, penable, pwrite,
		input  prdata, pready
	);

	// instruction rom side
	modport completer (
		input  paddr, psel, penable, pwrite,
		output prdata, pready
	);

endinterface

//--- hdl/fetch_ctrl.sv
// ==========================================================================
// fetch control
// sequences apb reads, waits on a held output, drops stale fetches
// ==========================================================================
`timescale 1ns/1ps

module fetch_ctrl (
	input  logic              i_clk,
	input  logic              i_nrst,
	input  logic              i_con_b,
	input  fetch_pkg::jump_e  i_con_j,
	input  logic              i_out_full,
	input  logic              i_ready,
	apb_if.requester          apb,
	output fetch_pkg::pc_sel_e o_pc_sel,
	output logic              o_pc_step,
	output logic              o_load,
	output logic              o_flush
);
	import fetch_pkg::*;

	fetch_state_e state_q;
	fetch_state_e state_d;
	logic         stale_q;
	logic         redirect;
	logic         complete;
	logic         blocked;
	logic         good;

	// ======================================================================
	// redirect decode
	// ======================================================================
	assign redirect = i_con_b || (i_con_j == J_JUMP) || (i_con_j == J_REG);

	// jump register wins over jump, jump over branch
	always_comb begin
		if (i_con_j == J_REG)
			o_pc_sel = PC_JR;
		else if (i_con_j == J_JUMP)
			o_pc_sel = PC_JUMP;
		else if (i_con_b)
			o_pc_sel = PC_BRANCH;
		else
			o_pc_sel = PC_SEQ;
	end

	// ======================================================================
	// transfer completion
	// ======================================================================
	assign complete = (state_q == ACCESS) && apb.pready;
	// output still held, word is refetched later from the same pc
	assign blocked  = complete && !stale_q && !redirect && i_out_full;
	assign good     = complete && !stale_q && !redirect && !i_out_full;

	assign o_load    = good;
	assign o_flush   = redirect;
	assign o_pc_step = good || redirect;

	// apb phases straight from the state
	assign apb.psel    = (state_q == SETUP) || (state_q == ACCESS);
	assign apb.penable = (state_q == ACCESS);
	assign apb.pwrite  = 1'b0;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:   state_d = SETUP;
			SETUP:  state_d = ACCESS;
			ACCESS: begin
				if (blocked)
					state_d = FULL;
				else if (complete)
					state_d = SETUP;
			end
			// decode accepting or a flush frees the register
			FULL:   begin
				if (i_ready || redirect)
					state_d = SETUP;
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			state_q <= IDLE;
			stale_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// redirect during a transfer marks its data as stale
			if (complete)
				stale_q <= 1'b0;
			else if (redirect && apb.psel)
				stale_q <= 1'b1;
		end
	end

endmodule

//--- hdl/pc_gen.sv
// ==========================================================================
// pc generation
// next pc mux, pc register, pc+4 adder and the apb fetch address
// ==========================================================================
`timescale 1ns/1ps

module pc_gen (
	input  logic                           i_clk,
	input  logic                           i_nrst,
	input  fetch_pkg::pc_sel_e             i_pc_sel,
	input  logic                           i_pc_step,
	input  logic [fetch_pkg::ADDR_W-1:0]   i_addr_b,
	input  logic [25:0]                    i_addr_j,
	input  logic [fetch_pkg::ADDR_W-1:0]   i_addr_jr,
	output logic [fetch_pkg::ADDR_W-1:0]   o_addr_pc,
	output logic [fetch_pkg::ADDR_W-1:0]   o_addr_pc4,
	apb_if.requester                       apb
);
	import fetch_pkg::*;

	logic [ADDR_W-1:0] pc_q;
	logic [ADDR_W-1:0] pc_d;
	logic [ADDR_W-1:0] pc4;
	logic [ADDR_W-1:0] jump_tgt;
	logic [ADDR_W-1:0] paddr_q;

	assign pc4      = pc_q + ADDR_W'(4);
	// region of the current pc, word index from the instruction
	assign jump_tgt = {pc_q[ADDR_W-1:ADDR_W-4], i_addr_j, 2'b00};

	always_comb begin
		pc_d = pc_q;
		if (i_pc_step) begin
			case (i_pc_sel)
				PC_SEQ:    pc_d = pc4;
				PC_BRANCH: pc_d = i_addr_b;
				PC_JUMP:   pc_d = jump_tgt;
				PC_JR:     pc_d = i_addr_jr;
				default:   pc_d = pc4;
			endcase
		end
	end

	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			pc_q    <= RESET_PC;
			paddr_q <= RESET_PC;
		end else begin
			pc_q <= pc_d;
			// fetch address frozen while a transfer is open
			if (!apb.psel || (apb.penable && apb.pready))
				paddr_q <= pc_d;
		end
	end

	assign apb.paddr  = paddr_q;
	assign o_addr_pc  = pc_q;
	assign o_addr_pc4 = pc4;

endmodule

//--- hdl/instr_rom_apb.sv
// ==========================================================================
// instruction rom
// apb completer with fixed wait states, contents from a hex image
// ==========================================================================
`timescale 1ns/1ps

module instr_rom_apb (
	input  logic       i_clk,
	input  logic       i_nrst,
	apb_if.completer   apb
);
	import fetch_pkg::*;

	localparam int IDX_W = $clog2(ROM_DEPTH);
	localparam int CNT_W = (ROM_WAIT > 0) ? $clog2(ROM_WAIT + 1) : 1;

	logic [INSTR_W-1:0] mem [ROM_DEPTH];
	logic [IDX_W-1:0]   idx;
	logic [CNT_W-1:0]   wait_q;
	logic               access;

	initial begin
		$readmemh("sim/imem.hex", mem);
	end

	// word address, wrapped to the rom depth
	assign idx = apb.paddr[2 +: IDX_W];

	assign access = apb.psel && apb.penable && !apb.pwrite;

	// ======================================================================
	// wait state counter
	// ======================================================================
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			wait_q <= '0;
		end else if (access && !apb.pready) begin
			wait_q <= wait_q + CNT_W'(1);
		end else begin
			// back to zero between transfers
			wait_q <= '0;
		end
	end

	assign apb.pready = access && (wait_q == CNT_W'(ROM_WAIT));
	assign apb.prdata = mem[idx];

endmodule

//--- hdl/if_id_reg.sv
// ==========================================================================
// fetch to decode register
// valid/ready stage for pc, pc+4 and instruction, with flush
// ==========================================================================
`timescale 1ns/1ps

module if_id_reg (
	input  logic                            i_clk,
	input  logic                            i_nrst,
	input  logic                            i_load,
	input  logic                            i_flush,
	input  logic                            i_ready,
	input  logic [fetch_pkg::ADDR_W-1:0]    i_addr_pc,
	input  logic [fetch_pkg::ADDR_W-1:0]    i_addr_pc4,
	input  logic [fetch_pkg::INSTR_W-1:0]   i_data_instr,
	output logic                            o_valid,
	output logic [fetch_pkg::ADDR_W-1:0]    o_addr_pc,
	output logic [fetch_pkg::ADDR_W-1:0]    o_addr_pc4,
	output logic [fetch_pkg::INSTR_W-1:0]   o_data_instr,
	output logic                            o_full
);

	// flush first, then a new word, then acceptance by decode
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst)
			o_valid <= 1'b0;
		else if (i_flush)
			o_valid <= 1'b0;
		else if (i_load)
			o_valid <= 1'b1;
		else if (i_ready)
			o_valid <= 1'b0;
	end

	always_ff @(posedge i_clk) begin
		if (i_load) begin
			o_addr_pc    <= i_addr_pc;
			o_addr_pc4   <= i_addr_pc4;
			o_data_instr <= i_data_instr;
		end
	end

	// held and not taken this cycle
	assign o_full = o_valid && !i_ready;

endmodule

//--- hdl/fetch_top.sv
// ==========================================================================
// fetch front end
// pc generation, apb instruction rom and the if/id register
// ==========================================================================
`timescale 1ns/1ps

module fetch_top (
	input  logic                            i_clk,
	input  logic                            i_nrst,
	input  logic                            i_con_b,
	input  logic [1:0]                      i_con_j,
	input  logic [fetch_pkg::ADDR_W-1:0]    i_addr_b,
	input  logic [25:0]                     i_addr_j,
	input  logic [fetch_pkg::ADDR_W-1:0]    i_addr_jr,
	input  logic                            i_ready,
	output logic                            o_valid,
	output logic [fetch_pkg::ADDR_W-1:0]    o_addr_pc,
	output logic [fetch_pkg::ADDR_W-1:0]    o_addr_pc4,
	output logic [fetch_pkg::INSTR_W-1:0]   o_data_instr
);
	import fetch_pkg::*;

	pc_sel_e           pc_sel;
	logic              pc_step;
	logic              load;
	logic              flush;
	logic              out_full;
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] pc4;

	apb_if apb_i ();

	// ======================================================================
	// control
	// ======================================================================
	fetch_ctrl ctrl_i (
		.i_clk      (i_clk),
		.i_nrst     (i_nrst),
		.i_con_b    (i_con_b),
		.i_con_j    (jump_e'(i_con_j)),
		.i_out_full (out_full),
		.i_ready    (i_ready),
		.apb        (apb_i),
		.o_pc_sel   (pc_sel),
		.o_pc_step  (pc_step),
		.o_load     (load),
		.o_flush    (flush)
	);

	// ======================================================================
	// datapath
	// ======================================================================
	pc_gen pc_i (
		.i_clk      (i_clk),
		.i_nrst     (i_nrst),
		.i_pc_sel   (pc_sel),
		.i_pc_step  (pc_step),
		.i_addr_b   (i_addr_b),
		.i_addr_j   (i_addr_j),
		.i_addr_jr  (i_addr_jr),
		.o_addr_pc  (pc),
		.o_addr_pc4 (pc4),
		.apb        (apb_i)
	);

	instr_rom_apb rom_i (
		.i_clk  (i_clk),
		.i_nrst (i_nrst),
		.apb    (apb_i)
	);

	if_id_reg out_i (
		.i_clk        (i_clk),
		.i_nrst       (i_nrst),
		.i_load       (load),
		.i_flush      (flush),
		.i_ready      (i_ready),
		.i_addr_pc    (pc),
		.i_addr_pc4   (pc4),
		.i_data_instr (apb_i.prdata),
		.o_valid      (o_valid),
		.o_addr_pc    (o_addr_pc),
		.o_addr_pc4   (o_addr_pc4),
		.o_data_instr (o_data_instr),
		.o_full       (out_full)
	);

endmodule

//--- sim/fetch_properties.sv
// ==========================================================================
// fetch properties
// apb read protocol and if/id output stability, bound into fetch_top
// ==========================================================================
`timescale 1ns/1ps

module fetch_properties (
	input logic                            i_clk,
	input logic                            i_nrst,
	input logic                            i_psel,
	input logic                            i_penable,
	input logic                            i_pready,
	input logic [fetch_pkg::ADDR_W-1:0]    i_paddr,
	input logic                            i_con_b,
	input logic [1:0]                      i_con_j,
	input logic                            i_ready,
	input logic                            i_valid,
	input logic [fetch_pkg::ADDR_W-1:0]    i_addr_pc,
	input logic [fetch_pkg::ADDR_W-1:0]    i_addr_pc4,
	input logic [fetch_pkg::INSTR_W-1:0]   i_data_instr
);
	import fetch_pkg::*;

	logic redirect;
	logic xfer_open;

	assign redirect  = i_con_b || (i_con_j == J_JUMP) || (i_con_j == J_REG);
	// transfer started and not completing this cycle
	assign xfer_open = i_psel && !(i_penable && i_pready);

	setup_then_access: assert property (@(posedge i_clk) disable iff (!i_nrst)
		i_psel && !i_penable |=> i_psel && i_penable)
		else $error("apb setup cycle not followed by an access cycle");

	transfer_held: assert property (@(posedge i_clk) disable iff (!i_nrst)
		xfer_open |=> i_psel && $stable(i_paddr))
		else $error("apb transfer dropped or paddr changed before pready");

	// ======================================================================
	// decode side
	// ======================================================================
	output_held: assert property (@(posedge i_clk) disable iff (!i_nrst)
		i_valid && !i_ready && !redirect |=> i_valid && $stable(i_addr_pc)
			&& $stable(i_addr_pc4) && $stable(i_data_instr))
		else $error("if/id output changed while held by decode");

endmodule

//--- sim/fetch_tb.sv
// ==========================================================================
// fetch front end testbench
// random redirects and back-pressure, checked against a pc model
// ==========================================================================
`timescale 1ns/1ps

module fetch_tb;
	import fetch_pkg::*;

	localparam int CLK_PERIOD  = 4;
	localparam int FETCH_CYC   = 2 + ROM_WAIT;
	localparam int RUN_CYCLES  = 2500 * FETCH_CYC;
	localparam int WDOG_CYCLES = 3000 * FETCH_CYC + 200;
	localparam int MIN_XFER    = 400;
	localparam int IDX_W       = $clog2(ROM_DEPTH);

	logic               i_clk;
	logic               i_nrst;
	logic               i_con_b;
	logic [1:0]         i_con_j;
	logic [ADDR_W-1:0]  i_addr_b;
	logic [25:0]        i_addr_j;
	logic [ADDR_W-1:0]  i_addr_jr;
	logic               i_ready;
	logic               o_valid;
	logic [ADDR_W-1:0]  o_addr_pc;
	logic [ADDR_W-1:0]  o_addr_pc4;
	logic [INSTR_W-1:0] o_data_instr;

	// reference model state
	logic [INSTR_W-1:0] model_mem [ROM_DEPTH];
	logic [ADDR_W-1:0]  exp_pc;
	logic               hold_q;
	logic [ADDR_W-1:0]  held_pc;
	logic [ADDR_W-1:0]  held_pc4;
	logic [INSTR_W-1:0] held_instr;
	integer             seed;
	int                 n_err;
	int                 n_xfer;
	int                 n_b;
	int                 n_j;
	int                 n_jr;

	fetch_top dut_i (
		.i_clk        (i_clk),
		.i_nrst       (i_nrst),
		.i_con_b      (i_con_b),
		.i_con_j      (i_con_j),
		.i_addr_b     (i_addr_b),
		.i_addr_j     (i_addr_j),
		.i_addr_jr    (i_addr_jr),
		.i_ready      (i_ready),
		.o_valid      (o_valid),
		.o_addr_pc    (o_addr_pc),
		.o_addr_pc4   (o_addr_pc4),
		.o_data_instr (o_data_instr)
	);

	bind fetch_top fetch_properties props_i (
		.i_clk        (i_clk),
		.i_nrst       (i_nrst),
		.i_psel       (apb_i.psel),
		.i_penable    (apb_i.penable),
		.i_pready     (apb_i.pready),
		.i_paddr      (apb_i.paddr),
		.i_con_b      (i_con_b),
		.i_con_j      (i_con_j),
		.i_ready      (i_ready),
		.i_valid      (o_valid),
		.i_addr_pc    (o_addr_pc),
		.i_addr_pc4   (o_addr_pc4),
		.i_data_instr (o_data_instr)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			n_err++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// jump register over jump over branch
	function automatic logic [ADDR_W-1:0] redirect_target();
		if (i_con_j == J_REG)
			return i_addr_jr;
		if (i_con_j == J_JUMP)
			return {exp_pc[ADDR_W-1:ADDR_W-4], i_addr_j, 2'b00};
		return i_addr_b;
	endfunction

	task automatic drive_inputs(input logic allow_redirect);
		logic [31:0] rnd;
		rnd = $random(seed);
		i_ready = (rnd % 100) < 70;
		// targets keep bit 27 clear so pc+4 never leaves its 256 MB region
		rnd = $random(seed);
		i_addr_b = rnd & 32'hf7ff_fffc;
		rnd = $random(seed);
		i_addr_j = rnd[25:0] & 26'h1ff_ffff;
		rnd = $random(seed);
		i_addr_jr = rnd & 32'hf7ff_fffc;
		i_con_b = 1'b0;
		i_con_j = J_NONE;
		rnd = $random(seed);
		if (allow_redirect && (rnd % 100) < 5) begin
			// combined requests exercise the priority
			case ((rnd >> 8) % 5)
				0: i_con_b = 1'b1;
				1: i_con_j = J_JUMP;
				2: i_con_j = J_REG;
				3: begin
					i_con_b = 1'b1;
					i_con_j = J_JUMP;
				end
				default: begin
					i_con_b = 1'b1;
					i_con_j = J_REG;
				end
			endcase
		end
	endtask

	// one cycle, entered just after the rising edge
	task automatic run_cycle();
		logic             redirect;
		logic [IDX_W-1:0] idx;
		if (hold_q) begin
			if (o_valid !== 1'b1) begin
				n_err++;
				$display("at %0t a held word was dropped while i_ready was low", $time);
			end
			check_value("o_addr_pc (held)", o_addr_pc, held_pc);
			check_value("o_addr_pc4 (held)", o_addr_pc4, held_pc4);
			check_value("o_data_instr (held)", o_data_instr, held_instr);
		end
		drive_inputs(n_xfer > 0);
		redirect = i_con_b || (i_con_j == J_JUMP) || (i_con_j == J_REG);
		if (redirect) begin
			exp_pc = redirect_target();
			if (i_con_j == J_REG)
				n_jr++;
			else if (i_con_j == J_JUMP)
				n_j++;
			else
				n_b++;
		end else if (o_valid && i_ready) begin
			idx = IDX_W'((exp_pc >> 2) % ROM_DEPTH);
			check_value("o_addr_pc", o_addr_pc, exp_pc);
			check_value("o_addr_pc4", o_addr_pc4, exp_pc + 32'd4);
			check_value("o_data_instr", o_data_instr, model_mem[idx]);
			exp_pc = exp_pc + 32'd4;
			n_xfer++;
		end
		hold_q     = o_valid && !i_ready && !redirect;
		held_pc    = o_addr_pc;
		held_pc4   = o_addr_pc4;
		held_instr = o_data_instr;
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================
	initial begin
		seed      = 32'h0afb_0503;
		n_err     = 0;
		n_xfer    = 0;
		n_b       = 0;
		n_j       = 0;
		n_jr      = 0;
		exp_pc    = RESET_PC;
		hold_q    = 1'b0;
		i_nrst    = 1'b0;
		i_con_b   = 1'b0;
		i_con_j   = 2'd0;
		i_addr_b  = '0;
		i_addr_j  = '0;
		i_addr_jr = '0;
		i_ready   = 1'b0;
		$readmemh("sim/imem.hex", model_mem);
		repeat (5) @(posedge i_clk);
		#1;
		if (o_valid !== 1'b0) begin
			n_err++;
			$display("o_valid is not low during reset");
		end
		i_nrst = 1'b1;
		for (int c = 0; c < RUN_CYCLES; c++) begin
			@(posedge i_clk);
			#1;
			run_cycle();
		end
		if (n_xfer < MIN_XFER) begin
			n_err++;
			$display("only %0d transfers reached decode, at least %0d needed",
				n_xfer, MIN_XFER);
		end
		if (n_b == 0 || n_j == 0 || n_jr == 0) begin
			n_err++;
			$display("not every redirect kind was exercised");
		end
		$display("errors %0d, transfers %0d, redirects b %0d j %0d jr %0d",
			n_err, n_xfer, n_b, n_j, n_jr);
		if (n_err == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		#(WDOG_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles, the run did not finish", WDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- compile.f
hdl/fetch_pkg.sv
hdl/apb_if.sv
hdl/fetch_ctrl.sv
hdl/pc_gen.sv
hdl/instr_rom_apb.sv
hdl/if_id_reg.sv
hdl/fetch_top.sv
sim/fetch_properties.sv
sim/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the fetch front end testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --assert --timescale 1ns/1ps --top-module fetch_tb \
	-f compile.f -o fetch_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log
grep -q "SIMULATION PASSED" sim.log && echo "result: pass" \
	|| { echo "result: fail"; exit 1; }

//--- sim/imem.hex
// one 32-bit instruction word per line, rom index 0 to 15
20080001
20090002
01095020
ac0a0000
8c0b0000
11490003
00000000
08000004
3c0c1000
358c0040
000c6880
01ae7022
0c000010
03e00008
2108ffff
1500fff1
